//--- project.f
+incdir+src
src/ccStreamPkg.sv
src/ccBusPkg.sv
src/graphPrep.sv
src/closureStage.sv
src/componentCounter.sv
src/ccRegs.sv
src/ccStreamCore.sv
tb/ccStreamCore_assert.sv
tb/ccStreamCore_tb.sv

//--- src/ccBusPkg.sv
`include "ccStream_params.svh"

package ccBusPkg;

    // Wishbone classic master to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  adr;
        logic [31:0] dat;
    } wbReq_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wbRsp_t;

    // Applied by the prep stage
    typedef struct packed {
        logic                 enable;
        logic [`CC_NODES-1:0] nodeMask;
    } ccConfig_t;

endpackage

//--- src/ccRegs.sv
`timescale 1ns/100ps
`include "ccStream_params.svh"

module ccRegs (
    input  logic                   clk,
    input  logic                   arstN,
    input  ccBusPkg::wbReq_t       wbReq,
    output ccBusPkg::wbRsp_t       wbRsp,
    input  ccStreamPkg::ccResult_t result,
    output ccBusPkg::ccConfig_t    cfg
);

    logic        access;
    logic        writeCtrl;
    logic        writeTotal;
    logic        writeConn;
    logic [31:0] readMux;
    logic [31:0] totalCount;
    logic [31:0] connCount;
    logic        ackQ;
    logic [31:0] rdDataQ;

    // New request seen and not yet acked
    assign access     = wbReq.cyc & wbReq.stb & ~ackQ;
    assign writeCtrl  = access & wbReq.we & (wbReq.adr == `CC_ADDR_CTRL);
    assign writeTotal = access & wbReq.we & (wbReq.adr == `CC_ADDR_TOTAL);
    assign writeConn  = access & wbReq.we & (wbReq.adr == `CC_ADDR_CONN);

    always_comb begin
        case (wbReq.adr)
            `CC_ADDR_CTRL:  readMux = {16'h0, cfg.nodeMask, 7'h0, cfg.enable};
            `CC_ADDR_TOTAL: readMux = totalCount;
            `CC_ADDR_CONN:  readMux = connCount;
            default:        readMux = 32'h0;
        endcase
    end

    // Single-cycle ack followed by at least one low cycle
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ackQ    <= 1'b0;
            rdDataQ <= 32'h0;
        end else begin
            ackQ <= access;
            if (access) begin
                rdDataQ <= readMux;
            end
        end
    end

    assign wbRsp = '{ack: ackQ, dat: rdDataQ};

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cfg.enable   <= 1'b1;
            cfg.nodeMask <= '1;
        end else if (writeCtrl) begin
            cfg.enable   <= wbReq.dat[0];
            cfg.nodeMask <= wbReq.dat[15:8];
        end
    end

    // Any write clears and wins over a result in the same cycle
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            totalCount <= 32'h0;
        end else if (writeTotal) begin
            totalCount <= 32'h0;
        end else if (result.valid) begin
            totalCount <= totalCount + 32'h1;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            connCount <= 32'h0;
        end else if (writeConn) begin
            connCount <= 32'h0;
        end else if (result.valid && result.connected) begin
            connCount <= connCount + 32'h1;
        end
    end

endmodule

//--- src/ccStreamCore.sv
`timescale 1ns/100ps

module ccStreamCore (
    input  logic                   clk,
    input  logic                   arstN,
    input  ccStreamPkg::graphIn_t  graphIn,
    output ccStreamPkg::ccResult_t result,
    input  ccBusPkg::wbReq_t       wbReq,
    output ccBusPkg::wbRsp_t       wbRsp
);

    ccBusPkg::ccConfig_t     cfg;
    // Entry 0 from prep, entry 3 into the counter
    ccStreamPkg::stageData_t stageChain [0:3];

    ccRegs regs (
        .clk    (clk),
        .arstN  (arstN),
        .wbReq  (wbReq),
        .wbRsp  (wbRsp),
        .result (result),
        .cfg    (cfg)
    );

    graphPrep prep (
        .clk      (clk),
        .arstN    (arstN),
        .cfg      (cfg),
        .graphIn  (graphIn),
        .stageOut (stageChain[0])
    );

    // Three squarings cover paths up to 8 hops
    for (genvar g = 0; g < 3; g++) begin : genClosure
        closureStage closure (
            .clk      (clk),
            .arstN    (arstN),
            .stageIn  (stageChain[g]),
            .stageOut (stageChain[g+1])
        );
    end

    componentCounter counter (
        .clk     (clk),
        .arstN   (arstN),
        .stageIn (stageChain[3]),
        .result  (result)
    );

endmodule

//--- src/ccStreamPkg.sv
`include "ccStream_params.svh"

package ccStreamPkg;

    // Row i, bit j set means an edge from node i to node j
    typedef struct packed {
        logic                                    valid;
        logic [`CC_TAG_W-1:0]                    tag;
        logic [`CC_NODES-1:0][`CC_NODES-1:0]     adj;
    } graphIn_t;

    // Reachability matrix in flight with the same row/column convention
    typedef struct packed {
        logic                                    valid;
        logic [`CC_TAG_W-1:0]                    tag;
        logic [`CC_NODES-1:0][`CC_NODES-1:0]     reach;
    } stageData_t;

    typedef struct packed {
        logic                                    valid;
        logic [`CC_TAG_W-1:0]                    tag;
        logic [`CC_COUNT_W-1:0]                  count;
        logic                                    connected;
    } ccResult_t;

endpackage

//--- src/ccStream_params.svh
`ifndef CC_STREAM_PARAMS_SVH
`define CC_STREAM_PARAMS_SVH

// Graph size and result widths
`define CC_NODES   8
`define CC_COUNT_W 4
`define CC_TAG_W   8

// Register byte addresses on the Wishbone port
`define CC_ADDR_CTRL  4'h0
`define CC_ADDR_TOTAL 4'h4
`define CC_ADDR_CONN  4'h8

`endif

//--- src/closureStage.sv
`timescale 1ns/100ps
`include "ccStream_params.svh"

module closureStage (
    input  logic                    clk,
    input  logic                    arstN,
    input  ccStreamPkg::stageData_t stageIn,
    output ccStreamPkg::stageData_t stageOut
);

    logic [`CC_NODES-1:0][`CC_NODES-1:0] squared;
    logic                                validQ;
    logic [`CC_TAG_W-1:0]                tagQ;
    logic [`CC_NODES-1:0][`CC_NODES-1:0] reachQ;

    // i reaches j when some k has i->k and k->j
    always_comb begin
        squared = '0;
        for (int i = 0; i < `CC_NODES; i++) begin
            for (int j = 0; j < `CC_NODES; j++) begin
                for (int k = 0; k < `CC_NODES; k++) begin
                    squared[i][j] = squared[i][j] | (stageIn.reach[i][k] & stageIn.reach[k][j]);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validQ <= 1'b0;
        end else begin
            validQ <= stageIn.valid;
        end
    end

    always_ff @(posedge clk) begin
        tagQ   <= stageIn.tag;
        reachQ <= squared;
    end

    assign stageOut = '{valid: validQ, tag: tagQ, reach: reachQ};

endmodule

//--- src/componentCounter.sv
`timescale 1ns/100ps
`include "ccStream_params.svh"

module componentCounter (
    input  logic                    clk,
    input  logic                    arstN,
    input  ccStreamPkg::stageData_t stageIn,
    output ccStreamPkg::ccResult_t  result
);

    logic [`CC_NODES-1:0]   leader;
    logic [`CC_NODES-1:0]   lowerNodes;
    logic [`CC_COUNT_W-1:0] leaderCount;
    logic                   validQ;
    logic [`CC_TAG_W-1:0]   tagQ;
    logic [`CC_COUNT_W-1:0] countQ;
    logic                   connectedQ;

    // Lowest-numbered enabled node of each component is its leader
    always_comb begin
        leader = '0;
        for (int i = 0; i < `CC_NODES; i++) begin
            lowerNodes = '0;
            for (int k = 0; k < i; k++) begin
                lowerNodes[k] = 1'b1;
            end
            leader[i] = stageIn.reach[i][i] & ~|(stageIn.reach[i] & lowerNodes);
        end
    end

    always_comb begin
        leaderCount = '0;
        for (int i = 0; i < `CC_NODES; i++) begin
            leaderCount = leaderCount + {{(`CC_COUNT_W-1){1'b0}}, leader[i]};
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validQ <= 1'b0;
        end else begin
            validQ <= stageIn.valid;
        end
    end

    always_ff @(posedge clk) begin
        tagQ       <= stageIn.tag;
        countQ     <= leaderCount;
        connectedQ <= (leaderCount == {{(`CC_COUNT_W-1){1'b0}}, 1'b1});
    end

    assign result = '{valid: validQ, tag: tagQ, count: countQ, connected: connectedQ};

endmodule

//--- src/graphPrep.sv
`timescale 1ns/100ps
`include "ccStream_params.svh"

module graphPrep (
    input  logic                   clk,
    input  logic                   arstN,
    input  ccBusPkg::ccConfig_t    cfg,
    input  ccStreamPkg::graphIn_t  graphIn,
    output ccStreamPkg::stageData_t stageOut
);

    logic [`CC_NODES-1:0][`CC_NODES-1:0] masked;
    logic [`CC_NODES-1:0][`CC_NODES-1:0] symAdj;
    logic                                validQ;
    logic [`CC_TAG_W-1:0]                tagQ;
    logic [`CC_NODES-1:0][`CC_NODES-1:0] reachQ;

    always_comb begin
        // Masked-off node loses its whole row and column
        for (int i = 0; i < `CC_NODES; i++) begin
            for (int j = 0; j < `CC_NODES; j++) begin
                masked[i][j] = graphIn.adj[i][j] & cfg.nodeMask[i] & cfg.nodeMask[j];
            end
        end
        // Symmetrize and give every enabled node a self-loop
        for (int i = 0; i < `CC_NODES; i++) begin
            for (int j = 0; j < `CC_NODES; j++) begin
                symAdj[i][j] = masked[i][j] | masked[j][i] | ((i == j) & cfg.nodeMask[i]);
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validQ <= 1'b0;
        end else begin
            validQ <= graphIn.valid & cfg.enable;
        end
    end

    always_ff @(posedge clk) begin
        tagQ   <= graphIn.tag;
        reachQ <= symAdj;
    end

    assign stageOut = '{valid: validQ, tag: tagQ, reach: reachQ};

endmodule

//--- tb/ccStreamCore_assert.sv
`timescale 1ns/100ps

module ccStreamCore_assert (
    input logic                   clk,
    input logic                   arstN,
    input ccStreamPkg::ccResult_t result,
    input ccBusPkg::wbReq_t       wbReq,
    input ccBusPkg::wbRsp_t       wbRsp
);

    int assertFailures = 0;

    // Ack is a single-cycle pulse
    ackPulse: assert property (@(posedge clk) disable iff (!arstN)
        wbRsp.ack |=> !wbRsp.ack)
        else begin
            assertFailures++;
            $error("Wishbone ack stayed high for two cycles");
        end

    // Request was present on the edge that raised ack
    ackOnRequest: assert property (@(posedge clk) disable iff (!arstN)
        $rose(wbRsp.ack) |-> $past(wbReq.cyc && wbReq.stb))
        else begin
            assertFailures++;
            $error("Wishbone ack rose without cyc and stb");
        end

    resultInReset: assert property (@(posedge clk)
        !arstN |-> !result.valid)
        else begin
            assertFailures++;
            $error("result.valid high during reset");
        end

endmodule

bind ccStreamCore ccStreamCore_assert portChecks (
    .clk    (clk),
    .arstN  (arstN),
    .result (result),
    .wbReq  (wbReq),
    .wbRsp  (wbRsp)
);

//--- tb/ccStreamCore_tb.sv
`timescale 1ns/100ps
`include "ccStream_params.svh"

module ccStreamCore_tb;

    localparam int maxCycles = 2000;

    logic                    clk = 1'b0;
    logic                    arstN;
    ccStreamPkg::graphIn_t   graphIn;
    ccStreamPkg::ccResult_t  result;
    ccBusPkg::wbReq_t        wbReq;
    ccBusPkg::wbRsp_t        wbRsp;

    int                      cycleCount = 0;
    // Expected results in order with their due cycles
    ccStreamPkg::ccResult_t  expQ[$];
    int                      dueQ[$];
    logic [`CC_NODES-1:0]    curMask;
    logic                    curEnable;
    int                      expTotal;
    int                      expConn;
    logic [31:0]             rdData;

    ccStreamCore i_dut (
        .clk     (clk),
        .arstN   (arstN),
        .graphIn (graphIn),
        .result  (result),
        .wbReq   (wbReq),
        .wbRsp   (wbRsp)
    );

    always #10 clk = ~clk;

    task automatic endOnError();
        $display("FAIL: see errors above");
        $fatal(1, "Stopped at first error");
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= maxCycles) begin
            $display("ERROR: run did not finish within %0d cycles", maxCycles);
            endOnError();
        end
    end

    task automatic compareResult(input ccStreamPkg::ccResult_t actual,
                                 input ccStreamPkg::ccResult_t expected, input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s got tag %0d count %0d conn %0b valid %0b",
                     $time, what, actual.tag, actual.count, actual.connected, actual.valid);
            $display("    expected tag %0d count %0d conn %0b valid %0b",
                     expected.tag, expected.count, expected.connected, expected.valid);
            endOnError();
        end
    endtask

    task automatic compareWord(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, actual, expected);
            endOnError();
        end
    endtask

    // Union-find over enabled nodes with each listed edge taken as undirected
    function automatic int modelComponents(input logic [`CC_NODES-1:0][`CC_NODES-1:0] adj,
                                           input logic [`CC_NODES-1:0] mask);
        int parent[`CC_NODES];
        int ra;
        int rb;
        int count;
        for (int i = 0; i < `CC_NODES; i++) parent[i] = i;
        for (int i = 0; i < `CC_NODES; i++) begin
            for (int j = 0; j < `CC_NODES; j++) begin
                if (adj[i][j] && mask[i] && mask[j]) begin
                    ra = i;
                    while (parent[ra] != ra) ra = parent[ra];
                    rb = j;
                    while (parent[rb] != rb) rb = parent[rb];
                    if (ra != rb) parent[ra] = rb;
                end
            end
        end
        count = 0;
        for (int i = 0; i < `CC_NODES; i++) begin
            if (mask[i] && parent[i] == i) count++;
        end
        return count;
    endfunction

    // Sparse directed bits giving roughly one edge in four after symmetrizing
    function automatic logic [`CC_NODES-1:0][`CC_NODES-1:0] randomGraph();
        return {$urandom, $urandom} & {$urandom, $urandom} & {$urandom, $urandom};
    endfunction

    task automatic nextCycle();
        @(posedge clk);
        #2;
    endtask

    task automatic driveGraph(input logic [`CC_NODES-1:0][`CC_NODES-1:0] adj,
                              input logic [`CC_TAG_W-1:0] tag, input int expCount);
        ccStreamPkg::ccResult_t expected;
        graphIn = '{valid: 1'b1, tag: tag, adj: adj};
        if (curEnable) begin
            expected = '{valid: 1'b1, tag: tag, count: expCount[`CC_COUNT_W-1:0],
                         connected: (expCount == 1)};
            expQ.push_back(expected);
            dueQ.push_back(cycleCount + 5);
            expTotal++;
            if (expCount == 1) expConn++;
        end
        nextCycle();
    endtask

    task automatic drainResults();
        while (dueQ.size() != 0) nextCycle();
        repeat (2) nextCycle();
    endtask

    task automatic wbWrite(input logic [3:0] adr, input logic [31:0] dat);
        wbReq = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
        do begin
            nextCycle();
        end while (!wbRsp.ack);
        wbReq = '0;
    endtask

    task automatic wbRead(input logic [3:0] adr, output logic [31:0] dat);
        wbReq = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 32'h0};
        do begin
            nextCycle();
        end while (!wbRsp.ack);
        dat = wbRsp.dat;
        wbReq = '0;
    endtask

    always @(posedge clk) begin : resultMonitor
        ccStreamPkg::ccResult_t expected;
        int due;
        #2;
        if (result.valid) begin
            if (expQ.size() == 0) begin
                $display("ERROR at %0t: result with tag %0d arrived with none outstanding",
                         $time, result.tag);
                endOnError();
            end else begin
                expected = expQ.pop_front();
                due = dueQ.pop_front();
                compareWord(32'(cycleCount), 32'(due), "result arrival cycle");
                compareResult(result, expected, "stream result");
            end
        end else if (dueQ.size() != 0 && dueQ[0] <= cycleCount) begin
            $display("ERROR at %0t: result for tag %0d never arrived", $time, expQ[0].tag);
            endOnError();
        end
    end

    task automatic testResetValues();
        wbRead(`CC_ADDR_CTRL, rdData);
        compareWord(rdData, 32'h0000_FF01, "CTRL after reset");
        wbRead(`CC_ADDR_TOTAL, rdData);
        compareWord(rdData, 32'h0, "TOTAL after reset");
        wbRead(`CC_ADDR_CONN, rdData);
        compareWord(rdData, 32'h0, "CONN after reset");
    endtask

    task automatic testFixedGraphs();
        logic [`CC_NODES-1:0][`CC_NODES-1:0] chain;
        logic [`CC_NODES-1:0][`CC_NODES-1:0] triangles;
        chain = '0;
        for (int i = 0; i < `CC_NODES - 1; i++) chain[i][i+1] = 1'b1;
        // One direction only with nodes 6 and 7 isolated
        triangles = '0;
        triangles[0][1] = 1'b1;
        triangles[1][2] = 1'b1;
        triangles[2][0] = 1'b1;
        triangles[3][4] = 1'b1;
        triangles[4][5] = 1'b1;
        triangles[3][5] = 1'b1;
        driveGraph('0, 8'h11, 8);
        driveGraph(chain, 8'h22, 1);
        driveGraph(triangles, 8'h33, 4);
        graphIn.valid = 1'b0;
        drainResults();
    endtask

    task automatic testRandomBurst();
        logic [`CC_NODES-1:0][`CC_NODES-1:0] g;
        for (int i = 0; i < 64; i++) begin
            g = randomGraph();
            driveGraph(g, i[`CC_TAG_W-1:0], modelComponents(g, curMask));
        end
        graphIn.valid = 1'b0;
        drainResults();
    endtask

    task automatic testNodeMask();
        logic [`CC_NODES-1:0][`CC_NODES-1:0] g;
        wbWrite(`CC_ADDR_CTRL, 32'h0000_0F01);
        curMask = 8'h0F;
        wbRead(`CC_ADDR_CTRL, rdData);
        compareWord(rdData, 32'h0000_0F01, "CTRL readback with mask 0x0F");
        for (int i = 0; i < 16; i++) begin
            g = randomGraph();
            driveGraph(g, 8'h80 + i[7:0], modelComponents(g, curMask));
        end
        graphIn.valid = 1'b0;
        wbWrite(`CC_ADDR_CTRL, 32'h0000_0001);
        curMask = 8'h00;
        driveGraph(randomGraph(), 8'hC0, 0);
        graphIn.valid = 1'b0;
        drainResults();
        wbWrite(`CC_ADDR_CTRL, 32'h0000_FF01);
        curMask = 8'hFF;
    endtask

    task automatic testDisable();
        logic [`CC_NODES-1:0][`CC_NODES-1:0] g;
        wbWrite(`CC_ADDR_CTRL, 32'h0000_FF00);
        curEnable = 1'b0;
        for (int i = 0; i < 8; i++) driveGraph(randomGraph(), 8'hD0 + i[7:0], 0);
        graphIn.valid = 1'b0;
        repeat (10) nextCycle();
        wbRead(`CC_ADDR_TOTAL, rdData);
        compareWord(rdData, 32'(expTotal), "TOTAL while disabled");
        wbWrite(`CC_ADDR_CTRL, 32'h0000_FF01);
        curEnable = 1'b1;
        for (int i = 0; i < 4; i++) begin
            g = randomGraph();
            driveGraph(g, 8'hE0 + i[7:0], modelComponents(g, curMask));
        end
        graphIn.valid = 1'b0;
        drainResults();
    endtask

    task automatic testCounters();
        wbRead(`CC_ADDR_TOTAL, rdData);
        compareWord(rdData, 32'(expTotal), "TOTAL count");
        wbRead(`CC_ADDR_CONN, rdData);
        compareWord(rdData, 32'(expConn), "CONN count");
        wbWrite(`CC_ADDR_TOTAL, 32'h1234_5678);
        wbRead(`CC_ADDR_TOTAL, rdData);
        compareWord(rdData, 32'h0, "TOTAL after clear");
        wbWrite(`CC_ADDR_CONN, 32'h0);
        wbRead(`CC_ADDR_CONN, rdData);
        compareWord(rdData, 32'h0, "CONN after clear");
        expTotal = 0;
        expConn = 0;
    endtask

    initial begin
        void'($urandom(32'h6c34_ab03));
        arstN     = 1'b1;
        graphIn   = '0;
        wbReq     = '0;
        curMask   = 8'hFF;
        curEnable = 1'b1;
        expTotal  = 0;
        expConn   = 0;
        #1 arstN = 1'b0;
        repeat (5) @(posedge clk);
        #2 arstN = 1'b1;
        testResetValues();
        testFixedGraphs();
        testRandomBurst();
        testNodeMask();
        testDisable();
        testCounters();
        // Bound port assertions report without stopping the run
        if (i_dut.portChecks.assertFailures == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
